//--- verilog/iob_apb_pkg.sv
package iob_apb_pkg;

   // Bus widths shared by the IOb side and the APB side
   localparam int unsigned ADDR_W = 12;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned STRB_W = DATA_W / 8;

   typedef logic [ADDR_W-1:0] addr_t;  // Byte address
   typedef logic [DATA_W-1:0] data_t;  // Data word
   typedef logic [STRB_W-1:0] strb_t;  // Byte strobes with all zero meaning read

   // IOb native request
   // valid is held with the other fields until ready
   typedef struct packed {
      logic  valid;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } iob_req_t;

   // IOb native response
   typedef struct packed {
      logic  ready;   // Request accepted
      logic  rvalid;  // Read data valid one cycle after acceptance
      data_t rdata;
   } iob_rsp_t;

   // APB request, driven by the bridge
   // sel and enable rise together with no setup phase
   typedef struct packed {
      logic  sel;
      logic  enable;
      logic  write;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } apb_req_t;

   // APB response, driven by the slave
   typedef struct packed {
      logic  ready;  // Transfer ends in this cycle
      data_t rdata;
   } apb_rsp_t;

endpackage

//--- verilog/regmap_pkg.sv
package regmap_pkg;

   // Word index into the register file for up to 8 registers
   typedef logic [2:0] reg_idx_t;

   // Where the word index sits in the byte address
   localparam int unsigned IDX_LSB = 2;
   localparam int unsigned IDX_MSB = IDX_LSB + $bits(reg_idx_t) - 1;

   // Index of the read-only identification word
   localparam reg_idx_t ID_IDX = '0;

   // Contents of the identification word
   localparam iob_apb_pkg::data_t ID_WORD = 32'h1AB0_0A01;

endpackage

//--- verilog/iob_iob2apb.sv
`timescale 1ns/1ps

module iob_iob2apb (
   input  logic                  clk_i,
   input  logic                  reset_i,

   // IOb side
   input  iob_apb_pkg::iob_req_t iob_req_i,
   output iob_apb_pkg::iob_rsp_t iob_rsp_o,

   // APB side
   output iob_apb_pkg::apb_req_t apb_req_o,
   input  iob_apb_pkg::apb_rsp_t apb_rsp_i
);

   typedef enum logic [1:0] {
      WAIT_VALID,    // Idle with enable following valid
      WAIT_READY,    // Transfer in progress
      READ_RECOVER   // One cycle with enable low after a read
   } state_e;

   state_e             state_q;
   state_e             state_d;
   logic               apb_enable;
   logic               apb_write;
   logic               read_done;
   logic               rvalid_q;
   iob_apb_pkg::data_t rdata_q;

   assign apb_write = |iob_req_i.wstrb;  // Any strobe set means write
   assign read_done = apb_enable & apb_rsp_i.ready & ~apb_write;

   always_comb begin
      state_d    = state_q;
      apb_enable = 1'b0;

      case (state_q)
         WAIT_VALID: begin
            if (iob_req_i.valid) begin
               apb_enable = 1'b1;  // Same cycle as valid
               if (!apb_rsp_i.ready) begin
                  state_d = WAIT_READY;
               end else if (!apb_write) begin
                  // Slave without wait states ends at once
                  state_d = READ_RECOVER;
               end
            end
         end
         WAIT_READY: begin
            apb_enable = 1'b1;
            if (apb_rsp_i.ready) begin
               // Writes go back to idle, so the next one follows without a gap
               state_d = apb_write ? WAIT_VALID : READ_RECOVER;
            end
         end
         READ_RECOVER: begin
            state_d = WAIT_VALID;  // enable stays low here
         end
         default: begin
            state_d = WAIT_VALID;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= WAIT_VALID;
      end else begin
         state_q <= state_d;
      end
   end

   // Read data and its strobe registered at the ready edge
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rvalid_q <= 1'b0;
         rdata_q  <= '0;
      end else begin
         rvalid_q <= read_done;  // Single cycle pulse
         if (read_done) begin
            rdata_q <= apb_rsp_i.rdata;
         end
      end
   end

   assign apb_req_o.sel    = apb_enable;
   assign apb_req_o.enable = apb_enable;
   assign apb_req_o.write  = apb_write;
   assign apb_req_o.addr   = iob_req_i.addr;
   assign apb_req_o.wdata  = iob_req_i.wdata;
   assign apb_req_o.wstrb  = iob_req_i.wstrb;

   assign iob_rsp_o.ready  = apb_rsp_i.ready;  // Accept when the slave completes
   assign iob_rsp_o.rvalid = rvalid_q;
   assign iob_rsp_o.rdata  = rdata_q;

endmodule

//--- verilog/apb_regfile.sv
`timescale 1ns/1ps

module apb_regfile #(
   parameter int unsigned NUM_REGS    = 8,  // Implemented registers up to 8
   parameter int unsigned WAIT_STATES = 2   // Wait cycles per transfer
) (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  iob_apb_pkg::apb_req_t apb_req_i,
   output iob_apb_pkg::apb_rsp_t apb_rsp_o
);

   localparam int unsigned NUM_BYTES = $bits(iob_apb_pkg::strb_t);
   localparam int unsigned CNT_W     = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

   typedef logic [CNT_W-1:0] wait_cnt_t;

   localparam wait_cnt_t CNT_LAST = wait_cnt_t'(WAIT_STATES);

   wait_cnt_t             wait_cnt_q;
   logic                  ready;
   logic                  write_en;
   logic                  idx_ok;
   regmap_pkg::reg_idx_t  idx;
   iob_apb_pkg::data_t    rdata;
   iob_apb_pkg::data_t    regs_q [NUM_REGS];

   assign idx = apb_req_i.addr[regmap_pkg::IDX_MSB:regmap_pkg::IDX_LSB];

   // Writable range excludes the ID word
   assign idx_ok = (idx != regmap_pkg::ID_IDX) && (int'(idx) < NUM_REGS);

   // Wait counter runs only while enable is high
   assign ready = apb_req_i.enable & (wait_cnt_q == CNT_LAST);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wait_cnt_q <= '0;
      end else if (!apb_req_i.enable || ready) begin
         wait_cnt_q <= '0;  // Ready for the next transfer
      end else begin
         wait_cnt_q <= wait_cnt_q + wait_cnt_t'(1);
      end
   end

   assign write_en = ready & apb_req_i.sel & apb_req_i.write & idx_ok;

   // Byte strobed writes into the writable range
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int r = 0; r < NUM_REGS; r++) begin
            regs_q[r] <= '0;
         end
      end else if (write_en) begin
         for (int b = 0; b < NUM_BYTES; b++) begin
            if (apb_req_i.wstrb[b]) begin
               regs_q[idx][8*b +: 8] <= apb_req_i.wdata[8*b +: 8];
            end
         end
      end
   end

   // Read mux
   always_comb begin
      if (idx == regmap_pkg::ID_IDX) begin
         rdata = regmap_pkg::ID_WORD;
      end else if (int'(idx) < NUM_REGS) begin
         rdata = regs_q[idx];
      end else begin
         rdata = '0;  // Unimplemented index
      end
   end

   assign apb_rsp_o.ready = ready;
   assign apb_rsp_o.rdata = rdata;

endmodule

//--- verilog/iob_apb_top.sv
`timescale 1ns/1ps

module iob_apb_top #(
   parameter int unsigned NUM_REGS    = 8,
   parameter int unsigned WAIT_STATES = 2
) (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  iob_apb_pkg::iob_req_t iob_req_i,
   output iob_apb_pkg::iob_rsp_t iob_rsp_o
);

   // APB link between bridge and register file
   iob_apb_pkg::apb_req_t apb_req;
   iob_apb_pkg::apb_rsp_t apb_rsp;

   iob_iob2apb bridge (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .iob_req_i (iob_req_i),
      .iob_rsp_o (iob_rsp_o),
      .apb_req_o (apb_req),
      .apb_rsp_i (apb_rsp)
   );

   apb_regfile #(
      .NUM_REGS    (NUM_REGS),
      .WAIT_STATES (WAIT_STATES)
   ) regs (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .apb_req_i (apb_req),
      .apb_rsp_o (apb_rsp)
   );

endmodule

//--- testbench/iob_apb_props.sv
`timescale 1ns/1ps

module iob_apb_props (
   input logic                  clk_i,
   input logic                  reset_i,
   input iob_apb_pkg::iob_req_t iob_req_i,
   input iob_apb_pkg::iob_rsp_t iob_rsp_i,
   input iob_apb_pkg::apb_req_t apb_req_i,
   input iob_apb_pkg::apb_rsp_t apb_rsp_i
);

   logic read_end;  // Read request accepted on the IOb side in this cycle

   assign read_end = iob_req_i.valid & iob_rsp_i.ready & ~(|iob_req_i.wstrb);

   // Transfer fields hold while the slave inserts wait states
   hold_while_waiting: assert property (@(posedge clk_i) disable iff (reset_i)
      apb_req_i.enable && !apb_rsp_i.ready |=>
         apb_req_i.enable && $stable(apb_req_i.addr) && $stable(apb_req_i.write))
      else $error("APB address, write or enable changed during wait states");

   rvalid_follows_read: assert property (@(posedge clk_i) disable iff (reset_i)
      read_end |=> iob_rsp_i.rvalid)
      else $error("rvalid missing in the cycle after a read completed");

   rvalid_only_after_read: assert property (@(posedge clk_i) disable iff (reset_i)
      iob_rsp_i.rvalid |-> $past(read_end))
      else $error("rvalid high without a read completing in the previous cycle");

   quiet_after_reset: assert property (@(posedge clk_i)
      $fell(reset_i) && !iob_req_i.valid |-> !apb_req_i.enable && !iob_rsp_i.rvalid)
      else $error("Bridge not idle in the first cycle after reset");

endmodule

bind iob_iob2apb iob_apb_props props (
   .clk_i     (clk_i),
   .reset_i   (reset_i),
   .iob_req_i (iob_req_i),
   .iob_rsp_i (iob_rsp_o),
   .apb_req_i (apb_req_o),
   .apb_rsp_i (apb_rsp_i)
);

//--- testbench/iob_apb_tb.sv
`timescale 1ns/1ps

module iob_apb_tb;

   localparam int unsigned NUM_REGS      = 6;
   localparam int unsigned WAIT_STATES   = 2;
   localparam int unsigned RESET_CYCLES  = 8;
   localparam int unsigned READY_TIMEOUT = 50;  // Cycles before a request is given up
   localparam int unsigned RANDOM_OPS    = 40;

   logic                  clk = 1'b0;
   logic                  reset;
   iob_apb_pkg::iob_req_t iob_req;
   iob_apb_pkg::iob_rsp_t iob_rsp;

   iob_apb_pkg::data_t    model [8];  // Expected register contents
   logic                  after_read; // Last request was a read accepted one cycle ago

   iob_apb_top #(
      .NUM_REGS    (NUM_REGS),
      .WAIT_STATES (WAIT_STATES)
   ) dut (
      .clk_i     (clk),
      .reset_i   (reset),
      .iob_req_i (iob_req),
      .iob_rsp_o (iob_rsp)
   );

   always #5 clk = ~clk;

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1, "Simulation stopped after the first error");
   endtask

   task automatic check_data(input string name, input iob_apb_pkg::data_t expected,
                             input iob_apb_pkg::data_t actual);
      if (actual !== expected) begin
         stop_run($sformatf("MISMATCH at %0t: %s expected 0x%08h got 0x%08h",
                            $time, name, expected, actual));
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         stop_run($sformatf("MISMATCH at %0t: %s expected %b got %b",
                            $time, name, expected, actual));
      end
   endtask

   function automatic iob_apb_pkg::addr_t word_addr(input regmap_pkg::reg_idx_t idx);
      return iob_apb_pkg::addr_t'({idx, 2'b00});
   endfunction

   // Value a read of this index should return
   function automatic iob_apb_pkg::data_t expected_read(input regmap_pkg::reg_idx_t idx);
      if (idx == 3'd0) begin
         return regmap_pkg::ID_WORD;
      end
      if (int'(idx) >= NUM_REGS) begin
         return '0;
      end
      return model[idx];
   endfunction

   task automatic model_write(input regmap_pkg::reg_idx_t idx, input iob_apb_pkg::data_t wdata,
                              input iob_apb_pkg::strb_t wstrb);
      iob_apb_pkg::data_t mask;
      mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
      if (idx != 3'd0 && int'(idx) < NUM_REGS) begin
         model[idx] = (model[idx] & ~mask) | (wdata & mask);
      end
   endtask

   // Counts cycles from valid to ready at each falling edge
   task automatic wait_ready(input int unsigned expected_wait);
      int unsigned cycles;
      cycles = 0;
      @(negedge clk);
      while (!iob_rsp.ready) begin
         cycles++;
         if (cycles > READY_TIMEOUT) begin
            stop_run("Timeout: ready never came for the pending request");
         end
         @(negedge clk);
      end
      if (cycles != expected_wait) begin
         stop_run($sformatf("MISMATCH at %0t: ready latency expected %0d got %0d",
                            $time, expected_wait, cycles));
      end
   endtask

   task automatic bus_write(input regmap_pkg::reg_idx_t idx, input iob_apb_pkg::data_t wdata,
                            input iob_apb_pkg::strb_t wstrb);
      iob_req.valid = 1'b1;
      iob_req.addr  = word_addr(idx);
      iob_req.wdata = wdata;
      iob_req.wstrb = wstrb;
      wait_ready(WAIT_STATES + (after_read ? 1 : 0));  // Recovery cycle after a read
      model_write(idx, wdata, wstrb);
      @(posedge clk);
      #1;
      check_bit("iob_rsp.rvalid", 1'b0, iob_rsp.rvalid);  // Writes get no rvalid
      after_read = 1'b0;
   endtask

   task automatic bus_read(input regmap_pkg::reg_idx_t idx);
      iob_apb_pkg::data_t expected;
      iob_req.valid = 1'b1;
      iob_req.addr  = word_addr(idx);
      iob_req.wdata = '0;
      iob_req.wstrb = '0;
      wait_ready(WAIT_STATES + (after_read ? 1 : 0));
      check_bit("iob_rsp.rvalid", 1'b0, iob_rsp.rvalid);  // Not yet in the ready cycle
      expected = expected_read(idx);
      @(posedge clk);
      #1;
      check_bit("iob_rsp.rvalid", 1'b1, iob_rsp.rvalid);
      check_data($sformatf("iob_rsp.rdata[%0d]", idx), expected, iob_rsp.rdata);
      after_read = 1'b1;
   endtask

   task automatic bus_idle(input int unsigned cycles);
      iob_req.valid = 1'b0;
      iob_req.wstrb = '0;
      repeat (cycles) begin
         @(negedge clk);
         check_bit("iob_rsp.ready", 1'b0, iob_rsp.ready);
         @(posedge clk);
         #1;
      end
      if (cycles > 0) begin
         after_read = 1'b0;
      end
   endtask

   task automatic test_reset_state();
      iob_req.valid = 1'b0;
      for (int c = 0; c < 4; c++) begin
         @(negedge clk);
         check_bit("iob_rsp.ready", 1'b0, iob_rsp.ready);
         check_bit("iob_rsp.rvalid", 1'b0, iob_rsp.rvalid);
         check_data("iob_rsp.rdata", '0, iob_rsp.rdata);
         @(posedge clk);
         #1;
      end
      for (int i = 0; i < NUM_REGS; i++) begin
         bus_read(regmap_pkg::reg_idx_t'(i));
         bus_idle(1);
      end
   endtask

   task automatic test_full_words();
      for (int i = 1; i < NUM_REGS; i++) begin
         bus_write(regmap_pkg::reg_idx_t'(i), $urandom, 4'hF);
         bus_idle(1);
         bus_read(regmap_pkg::reg_idx_t'(i));
         bus_idle(1);
      end
      for (int i = 1; i < NUM_REGS; i++) begin  // No aliasing between registers
         bus_read(regmap_pkg::reg_idx_t'(i));
         bus_idle(1);
      end
   endtask

   task automatic test_byte_strobes();
      iob_apb_pkg::strb_t patterns [6] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h5, 4'hA};
      for (int i = 1; i < NUM_REGS; i++) begin
         bus_write(regmap_pkg::reg_idx_t'(i), $urandom, 4'hF);
         for (int p = 0; p < 6; p++) begin
            bus_write(regmap_pkg::reg_idx_t'(i), $urandom, patterns[p]);
            bus_idle(1);
            bus_read(regmap_pkg::reg_idx_t'(i));
            bus_idle(1);
         end
      end
   endtask

   // ID word and the unimplemented indices 6 and 7
   task automatic test_protected();
      regmap_pkg::reg_idx_t targets [3] = '{3'd0, 3'd6, 3'd7};
      for (int t = 0; t < 3; t++) begin
         bus_write(targets[t], 32'hFFFF_FFFF, 4'hF);
         bus_idle(1);
         bus_read(targets[t]);
         bus_idle(1);
      end
      for (int i = 1; i < NUM_REGS; i++) begin  // Ignored writes leave the others alone
         bus_read(regmap_pkg::reg_idx_t'(i));
         bus_idle(1);
      end
   endtask

   task automatic test_random_traffic();
      regmap_pkg::reg_idx_t idx;
      iob_apb_pkg::strb_t   strb;
      for (int n = 0; n < RANDOM_OPS; n++) begin
         idx = regmap_pkg::reg_idx_t'($urandom_range(0, 7));
         if ($urandom_range(0, 1) == 0) begin
            bus_read(idx);
         end else begin
            strb = iob_apb_pkg::strb_t'($urandom_range(1, 15));
            bus_write(idx, $urandom, strb);
         end
      end
      bus_idle(2);
   endtask

   initial begin
      void'($urandom(32'h4cfe5342));
      reset      = 1'b1;
      iob_req    = '0;
      after_read = 1'b0;
      foreach (model[i]) begin
         model[i] = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;

      test_reset_state();
      test_full_words();
      test_byte_strobes();
      test_protected();
      test_random_traffic();

      $display("Regression passed");
      $finish;
   end

endmodule

//--- list.f
verilog/iob_apb_pkg.sv
verilog/regmap_pkg.sv
verilog/iob_iob2apb.sv
verilog/apb_regfile.sv
verilog/iob_apb_top.sv
testbench/iob_apb_props.sv
testbench/iob_apb_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= iob_apb_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Regression failed
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run did not finish"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
